/* hdl/snd_chip_top.sv */
// Programmable sound chip top with register file, LFO and voice
module snd_chip_top import snd_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               wr,
	input  snd_reg_e           addr,
	input  logic [WDATA_W-1:0] wdata,
	output logic               spkr
);

	snd_cfg_t          cfg;
	logic              tick;        // One clock in TICK_DIV
	logic              lfo_state;
	logic [FREQ_W-1:0] lfo_delta;

	snd_regs u_regs (
		.clk   (clk),
		.rst   (rst),
		.wr    (wr),
		.addr  (addr),
		.wdata (wdata),
		.cfg   (cfg)
	);

	snd_lfo u_lfo (
		.clk       (clk),
		.rst       (rst),
		.lfo_freq  (cfg.lfo_freq),
		.lfo_shift (cfg.lfo_shift),
		.tick      (tick),
		.lfo_state (lfo_state),
		.lfo_delta (lfo_delta)
	);

	snd_voice u_voice (
		.clk       (clk),
		.rst       (rst),
		.tick      (tick),
		.cfg       (cfg),
		.lfo_state (lfo_state),
		.lfo_delta (lfo_delta),
		.spkr      (spkr)
	);

endmodule

/* hdl/snd_lfo.sv */
// Chip prescaler and low-frequency oscillator producing the modulation delta
module snd_lfo import snd_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [LFO_FREQ_W-1:0] lfo_freq,
	input  logic [2:0]            lfo_shift,
	output logic                  tick,
	output logic                  lfo_state,
	output logic [FREQ_W-1:0]     lfo_delta
);

	logic [PRESC_W-1:0]   presc;      // Free-running divide by TICK_DIV
	logic [LFO_CNT_W-1:0] lfo_count;
	logic [LFO_CNT_W-1:0] lfo_reload;
	logic                 lfo_zero;
	logic [FREQ_W-1:0]    triangle;

	// Prescaler sits at zero during reset, so tick stays high there
	always_ff @(posedge clk) begin
		if (rst) begin
			presc <= '0;
		end else begin
			presc <= presc + 1'b1;
		end
	end

	assign tick = (presc == '0);

	// Frequency field scaled up by 256
	assign lfo_reload = {lfo_freq, {(LFO_CNT_W - LFO_FREQ_W){1'b0}}};
	assign lfo_zero   = (lfo_count == '0);

	always_ff @(posedge clk) begin
		if (tick) begin
			if (rst || lfo_zero) begin
				lfo_count <= lfo_reload;
			end else begin
				lfo_count <= lfo_count - 1'b1;
			end
		end
	end

	// Square output flips once per LFO half period
	always_ff @(posedge clk) begin
		if (rst) begin
			lfo_state <= 1'b0;
		end else if (tick && lfo_zero) begin
			lfo_state <= ~lfo_state;
		end
	end

	// Top counter bits, folded over when the MSB is set
	always_comb begin
		if (lfo_count[LFO_CNT_W-1]) begin
			triangle = ~lfo_count[LFO_CNT_W-1 -: FREQ_W];
		end else begin
			triangle = lfo_count[LFO_CNT_W-1 -: FREQ_W];
		end
	end

	assign lfo_delta = triangle >> lfo_shift;   // Depth control

endmodule

/* hdl/snd_lfsr.sv */
// Galois LFSR noise source that steps on enable
module snd_lfsr import snd_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              enable,
	output logic [LFSR_W-1:0] lfsr
);

	logic [LFSR_W-1:0] lfsr_next;

	// Shift right, fold taps back in when a one drops out
	always_comb begin
		if (lfsr[0]) begin
			lfsr_next = (lfsr >> 1) ^ LFSR_TAPS;
		end else begin
			lfsr_next = lfsr >> 1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= LFSR_SEED;
		end else if (enable) begin
			lfsr <= lfsr_next;
		end
	end

endmodule

/* hdl/snd_pkg.sv */
// Sound chip package with widths, register map, configuration struct and LFSR constants
package snd_pkg;

	// Field and counter widths
	localparam int FREQ_W     = 12;               // VCO and noise frequency fields
	localparam int LFO_FREQ_W = 10;               // LFO frequency field
	localparam int LFO_CNT_W  = 18;               // LFO counter, lfo_freq then 8 zeros
	localparam int OSC_CNT_W  = 13;               // VCO and noise counters
	localparam int WDATA_W    = 12;               // Host write data

	// Prescaler that times every oscillator
	localparam int TICK_DIV = 16;                 // One tick per 16 clocks
	localparam int PRESC_W  = $clog2(TICK_DIV);

	// Noise generator
	localparam int          LFSR_W    = 16;
	localparam logic [15:0] LFSR_TAPS = 16'h100B; // Galois tap mask
	localparam logic [15:0] LFSR_SEED = 16'h0001; // Value held during reset

	// Host register map
	typedef enum logic [1:0] {
		REG_VCO_FREQ   = 2'd0,
		REG_NOISE_FREQ = 2'd1,
		REG_LFO_FREQ   = 2'd2,
		REG_CTRL       = 2'd3
	} snd_reg_e;

	// REG_CTRL bit positions in wdata
	localparam int CTRL_MIXER_LSB = 0;            // Bits 2:0
	localparam int CTRL_SHIFT_LSB = 3;            // Bits 5:3
	localparam int CTRL_VCO_SEL   = 6;
	localparam int CTRL_NOISE_SEL = 7;

	// Mixer enable bits, ordered {LFO, noise, VCO}
	localparam int MIX_VCO   = 0;
	localparam int MIX_NOISE = 1;
	localparam int MIX_LFO   = 2;

	// Full chip configuration as seen by the datapath
	typedef struct packed {
		logic [FREQ_W-1:0]     vco_freq;
		logic [FREQ_W-1:0]     noise_freq;
		logic [LFO_FREQ_W-1:0] lfo_freq;
		logic                  vco_select;    // LFO modulates VCO
		logic                  noise_select;  // LFO modulates noise
		logic [2:0]            lfo_shift;     // Modulation depth, larger is shallower
		logic [2:0]            mixer;         // Source enables {LFO, noise, VCO}
	} snd_cfg_t;

endpackage

/* hdl/snd_regs.sv */
// Configuration register file written by host strobe, address and data
module snd_regs import snd_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               wr,
	input  snd_reg_e           addr,
	input  logic [WDATA_W-1:0] wdata,
	output snd_cfg_t           cfg
);

	// Control word fields unpacked from wdata
	logic [2:0] ctrl_mixer;
	logic [2:0] ctrl_shift;
	logic       ctrl_vco_sel;
	logic       ctrl_noise_sel;

	assign ctrl_mixer     = wdata[CTRL_MIXER_LSB +: 3];
	assign ctrl_shift     = wdata[CTRL_SHIFT_LSB +: 3];
	assign ctrl_vco_sel   = wdata[CTRL_VCO_SEL];
	assign ctrl_noise_sel = wdata[CTRL_NOISE_SEL];

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg <= '0;                                   // Everything off and zero
		end else if (wr) begin
			case (addr)
				REG_VCO_FREQ: begin
					cfg.vco_freq <= wdata[FREQ_W-1:0];
				end
				REG_NOISE_FREQ: begin
					cfg.noise_freq <= wdata[FREQ_W-1:0];
				end
				REG_LFO_FREQ: begin
					cfg.lfo_freq <= wdata[LFO_FREQ_W-1:0];   // Upper bits dropped
				end
				REG_CTRL: begin
					cfg.mixer        <= ctrl_mixer;
					cfg.lfo_shift    <= ctrl_shift;
					cfg.vco_select   <= ctrl_vco_sel;
					cfg.noise_select <= ctrl_noise_sel;
				end
				default: begin
					cfg <= cfg;
				end
			endcase
		end
	end

endmodule

/* hdl/snd_tone_osc.sv */
// Reloadable down-counter oscillator that toggles its state at terminal count
module snd_tone_osc import snd_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 tick,
	input  logic [OSC_CNT_W-1:0] reload,
	input  logic                 gate,
	output logic                 at_zero,
	output logic                 state
);

	logic [OSC_CNT_W-1:0] count;

	assign at_zero = (count == '0);

	// Counter only moves on tick cycles, reset loads like a terminal count
	always_ff @(posedge clk) begin
		if (tick) begin
			if (rst || at_zero) begin
				count <= reload;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	// Output flips at terminal count when the gate allows it
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= 1'b0;
		end else if (tick && at_zero && gate) begin
			state <= ~state;
		end
	end

endmodule

/* hdl/snd_voice.sv */
// Tone and noise oscillators with the noise LFSR and the registered mixer
module snd_voice import snd_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              tick,
	input  snd_cfg_t          cfg,
	input  logic              lfo_state,
	input  logic [FREQ_W-1:0] lfo_delta,
	output logic              spkr
);

	logic [OSC_CNT_W-1:0] vco_reload;
	logic [OSC_CNT_W-1:0] noise_reload;
	logic                 vco_state;
	logic                 noise_zero;
	logic                 noise_state;
	logic [LFSR_W-1:0]    lfsr;
	logic [2:0]           sources;    // {LFO, noise, VCO}

	// Base frequency plus optional LFO offset with carry in the top bit
	function automatic logic [OSC_CNT_W-1:0] mod_reload(
		input logic [FREQ_W-1:0] freq,
		input logic              sel,
		input logic [FREQ_W-1:0] delta
	);
		logic [OSC_CNT_W-1:0] offset;
		offset = sel ? OSC_CNT_W'(delta) : '0;
		return OSC_CNT_W'(freq) + offset;
	endfunction

	assign vco_reload   = mod_reload(cfg.vco_freq, cfg.vco_select, lfo_delta);
	assign noise_reload = mod_reload(cfg.noise_freq, cfg.noise_select, lfo_delta);

	snd_tone_osc vco_osc (
		.clk     (clk),
		.rst     (rst),
		.tick    (tick),
		.reload  (vco_reload),
		.gate    (1'b1),          // Plain square wave
		.at_zero (),
		.state   (vco_state)
	);

	snd_tone_osc noise_osc (
		.clk     (clk),
		.rst     (rst),
		.tick    (tick),
		.reload  (noise_reload),
		.gate    (lfsr[0]),       // Random toggling
		.at_zero (noise_zero),
		.state   (noise_state)
	);

	snd_lfsr noise_lfsr (
		.clk    (clk),
		.rst    (rst),
		.enable (tick && noise_zero),
		.lfsr   (lfsr)
	);

	assign sources = {lfo_state, noise_state, vco_state};

	// Disabled sources read as one so they drop out of the AND
	always_ff @(posedge clk) begin
		if (rst) begin
			spkr <= 1'b0;
		end else if (tick) begin
			spkr <= &(sources | ~cfg.mixer);
		end
	end

endmodule

/* sim/snd_model.svh */
// Cycle-level reference model of the sound chip, stepped once per clock edge
`ifndef SND_MODEL_SVH
`define SND_MODEL_SVH

// Model copy of the host registers
logic [11:0] m_vco_freq   = '0;
logic [11:0] m_noise_freq = '0;
logic [9:0]  m_lfo_freq   = '0;
logic        m_vco_sel    = 1'b0;
logic        m_noise_sel  = 1'b0;
logic [2:0]  m_shift      = '0;
logic [2:0]  m_mixer      = '0;

// Model timing, counters and oscillator states
logic [3:0]  m_presc       = '0;
logic [17:0] m_lfo_count   = '0;
logic        m_lfo_state   = 1'b0;
logic [12:0] m_vco_count   = '0;
logic        m_vco_state   = 1'b0;
logic [12:0] m_noise_count = '0;
logic        m_noise_state = 1'b0;
logic [15:0] m_lfsr        = LFSR_SEED;
logic        m_spkr        = 1'b0;

task automatic predict_cycle(
	input logic        r,
	input logic        w,
	input logic [1:0]  a,
	input logic [11:0] d
);
	logic        tick;
	logic        lfo_zero;
	logic        vco_zero;
	logic        noise_zero;
	logic [11:0] tri_wave;
	logic [11:0] delta;
	logic [12:0] vco_rl;
	logic [12:0] noise_rl;
	logic [15:0] lfsr_shifted;

	tick       = (m_presc == 4'd0);
	lfo_zero   = (m_lfo_count == 18'd0);
	vco_zero   = (m_vco_count == 13'd0);
	noise_zero = (m_noise_count == 13'd0);

	tri_wave = m_lfo_count[17:6];
	if (m_lfo_count[17]) begin
		tri_wave = ~tri_wave;                      // Falling half of the triangle
	end
	delta    = tri_wave >> m_shift;
	vco_rl   = {1'b0, m_vco_freq} + (m_vco_sel ? {1'b0, delta} : 13'd0);
	noise_rl = {1'b0, m_noise_freq} + (m_noise_sel ? {1'b0, delta} : 13'd0);

	lfsr_shifted = {1'b0, m_lfsr[15:1]};
	if (m_lfsr[0]) begin
		lfsr_shifted = lfsr_shifted ^ LFSR_TAPS;
	end

	// Speaker takes the source states from before this edge
	if (r) begin
		m_spkr = 1'b0;
	end else if (tick) begin
		m_spkr = (m_vco_state | ~m_mixer[0]) & (m_noise_state | ~m_mixer[1]) &
			(m_lfo_state | ~m_mixer[2]);
	end

	if (r) begin
		m_vco_state   = 1'b0;
		m_noise_state = 1'b0;
		m_lfo_state   = 1'b0;
		m_lfsr        = LFSR_SEED;
	end else if (tick) begin
		if (vco_zero) begin
			m_vco_state = ~m_vco_state;
		end
		if (noise_zero && m_lfsr[0]) begin
			m_noise_state = ~m_noise_state;            // Noise gated by the LFSR
		end
		if (lfo_zero) begin
			m_lfo_state = ~m_lfo_state;
		end
		if (noise_zero) begin
			m_lfsr = lfsr_shifted;
		end
	end

	// Counters load on every tick while reset is high
	if (tick) begin
		m_vco_count   = (r || vco_zero) ? vco_rl : m_vco_count - 13'd1;
		m_noise_count = (r || noise_zero) ? noise_rl : m_noise_count - 13'd1;
		m_lfo_count   = (r || lfo_zero) ? {m_lfo_freq, 8'h00} : m_lfo_count - 18'd1;
	end
	m_presc = r ? 4'd0 : m_presc + 4'd1;

	if (r) begin
		m_vco_freq   = '0;
		m_noise_freq = '0;
		m_lfo_freq   = '0;
		m_vco_sel    = 1'b0;
		m_noise_sel  = 1'b0;
		m_shift      = '0;
		m_mixer      = '0;
	end else if (w) begin
		case (a)
			REG_VCO_FREQ:   m_vco_freq   = d;
			REG_NOISE_FREQ: m_noise_freq = d;
			REG_LFO_FREQ:   m_lfo_freq   = d[9:0];
			default: begin
				m_mixer     = d[2:0];                  // Control word layout
				m_shift     = d[5:3];
				m_vco_sel   = d[6];
				m_noise_sel = d[7];
			end
		endcase
	end
endtask

`endif

/* sim/tb_snd.sv */
// Testbench for the sound chip with random register writes checked against a model
module tb_snd import snd_pkg::*; ();

	localparam int EDGE_LIMIT = 12000;   // Cycles allowed between spkr edges

	logic        clk;
	logic        rst;
	logic        wr;
	snd_reg_e    addr;
	logic [11:0] wdata;
	logic        spkr;

	// Values applied at the next rising edge
	logic        nxt_rst;
	logic        nxt_wr;
	snd_reg_e    nxt_addr;
	logic [11:0] nxt_wdata;

	integer seed;

	`include "snd_model.svh"

	snd_chip_top uut (
		.clk   (clk),
		.rst   (rst),
		.wr    (wr),
		.addr  (addr),
		.wdata (wdata),
		.spkr  (spkr)
	);

	always #50 clk = ~clk;

	task automatic stop_with_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("error %s: got 0x%h expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	// Model steps on the inputs the DUT samples and spkr is checked mid-cycle
	task automatic clock_cycle();
		@(posedge clk);
		predict_cycle(rst, wr, addr, wdata);
		rst   <= nxt_rst;
		wr    <= nxt_wr;
		addr  <= nxt_addr;
		wdata <= nxt_wdata;
		@(negedge clk);
		check_value("spkr", spkr, m_spkr);
	endtask

	task automatic run_cycles(input int n);
		repeat (n) begin
			clock_cycle();
		end
	endtask

	task automatic write_reg(input snd_reg_e a, input logic [11:0] d);
		nxt_wr    = 1'b1;
		nxt_addr  = a;
		nxt_wdata = d;
		clock_cycle();
		nxt_wr = 1'b0;
	endtask

	function automatic logic [11:0] ctrl_word(input logic [2:0] mixer,
		input logic [2:0] shift, input logic vco_sel, input logic noise_sel);
		return {4'b0000, noise_sel, vco_sel, shift, mixer};
	endfunction

	// Keeps rst high through 16 rising edges including the one already driven
	task automatic hold_reset();
		repeat (15) begin
			clock_cycle();
			check_value("spkr", spkr, 1'b0);
		end
		nxt_rst = 1'b0;
		clock_cycle();
		check_value("spkr", spkr, 1'b0);     // Still before the first tick
	endtask

	task automatic wait_for_tick();
		int n;
		n = 0;
		while (uut.tick !== 1'b1 && n < 2 * TICK_DIV) begin
			clock_cycle();
			n++;
		end
		if (uut.tick !== 1'b1) begin
			$display("timeout: no prescaler tick seen within %0d cycles", 2 * TICK_DIV);
			stop_with_failure();
		end
	endtask

	task automatic wait_for_spkr_edge(input int limit, output int waited);
		logic old;
		old = spkr;
		clock_cycle();
		waited = 1;
		while (spkr === old && waited < limit) begin
			clock_cycle();
			waited++;
		end
		if (spkr === old) begin
			$display("timeout: spkr did not toggle within %0d cycles", limit);
			stop_with_failure();
		end
	endtask

	initial begin
		int          f;
		int          i;
		int          waited;
		logic [2:0]  shift;
		snd_reg_e    a;
		logic [11:0] d;

		clk       = 1'b0;
		rst       = 1'b1;
		wr        = 1'b0;
		addr      = REG_VCO_FREQ;
		wdata     = '0;
		nxt_rst   = 1'b1;
		nxt_wr    = 1'b0;
		nxt_addr  = REG_VCO_FREQ;
		nxt_wdata = '0;
		seed      = 32'h171a;

		hold_reset();

		// VCO alone with half period of TICK_DIV cycles per count step
		write_reg(REG_CTRL, ctrl_word(3'b001, 3'd0, 1'b0, 1'b0));
		for (i = 0; i < 6; i++) begin
			f = $random(seed) & 15;
			write_reg(REG_VCO_FREQ, 12'(f));
			wait_for_spkr_edge(EDGE_LIMIT, waited);  // Old period may still be running
			wait_for_spkr_edge(EDGE_LIMIT, waited);
			wait_for_spkr_edge(EDGE_LIMIT, waited);
			check_value("vco_half_period", waited, TICK_DIV * (f + 1));
		end

		// LFO bends the VCO reload
		write_reg(REG_LFO_FREQ, 12'(1 + ($random(seed) & 3)));
		write_reg(REG_VCO_FREQ, 12'($random(seed) & 15));
		for (i = 0; i < 3; i++) begin
			shift = 3'($random(seed));
			write_reg(REG_CTRL, ctrl_word(3'b001, shift, 1'b1, 1'b0));
			repeat (12) begin
				wait_for_spkr_edge(EDGE_LIMIT, waited);
			end
		end

		// Noise alone
		write_reg(REG_NOISE_FREQ, 12'($random(seed) & 7));
		for (i = 0; i < 2; i++) begin
			write_reg(REG_CTRL, ctrl_word(3'b010, 3'($random(seed)), 1'b0, 1'($random(seed))));
			repeat (8) begin
				wait_for_spkr_edge(EDGE_LIMIT, waited);
			end
		end

		// Every mixer setting
		for (i = 0; i < 8; i++) begin
			write_reg(REG_CTRL, ctrl_word(3'(i), 3'd2, 1'b1, 1'b1));
			if (i == 0) begin
				clock_cycle();                        // cfg picks up the write
				wait_for_tick();
				repeat (64) begin
					clock_cycle();
					check_value("spkr", spkr, 1'b1);   // Nothing enabled
				end
			end else begin
				run_cycles(800);
			end
		end

		// Random writes at random times
		repeat (300) begin
			run_cycles($random(seed) & 31);
			a = snd_reg_e'($random(seed) & 3);
			d = 12'($random(seed));
			case (a)
				REG_LFO_FREQ: d = d & 12'h007;
				REG_CTRL:     d = d & 12'h0ff;
				default:      d = d & 12'h03f;
			endcase
			write_reg(a, d);
		end

		// Fresh reset and a high LFO count so the triangle folds over
		nxt_rst = 1'b1;
		clock_cycle();
		hold_reset();
		write_reg(REG_LFO_FREQ, 12'h3ff);
		write_reg(REG_VCO_FREQ, 12'($random(seed) & 15));
		write_reg(REG_CTRL, ctrl_word(3'b001, 3'd0, 1'b1, 1'b1));
		repeat (16) begin
			wait_for_spkr_edge(EDGE_LIMIT, waited);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

/* tb.f */
+incdir+sim
hdl/snd_pkg.sv
hdl/snd_regs.sv
hdl/snd_lfo.sv
hdl/snd_tone_osc.sv
hdl/snd_lfsr.sv
hdl/snd_voice.sv
hdl/snd_chip_top.sv
sim/tb_snd.sv
